// ==== common/core_av_pkg.sv ====
////////////////////////////////////////
// core av package
// widths, defaults and bundles shared by
// the video conditioner and the i2s path
////////////////////////////////////////

`default_nettype none

package core_av_pkg;

  ////////////////////////////////////////
  // video

  // 8 bits per channel, red on top
  typedef struct packed {
    logic [7:0] r;
    logic [7:0] g;
    logic [7:0] b;
  } rgb_t;

  // raw video as the console core makes it
  typedef struct packed {
    logic hblank;
    logic vblank;
    logic hsync;
    logic vsync;
    rgb_t color;
  } nes_video_t;

  // conditioned video toward the scaler
  typedef struct packed {
    logic de;
    logic hs;
    logic vs;
    rgb_t rgb;
  } scaler_video_t;

  // pixel ticks from raw hsync edge to output hs pulse
  localparam int HS_DELAY_DEFAULT = 7;

  ////////////////////////////////////////
  // audio

  // one stereo sample pair
  typedef struct packed {
    logic signed [15:0] left;
    logic signed [15:0] right;
  } audio_sample_t;

  // channel on the wire, lrck low is left
  typedef enum logic {
    chan_left  = 1'b0,
    chan_right = 1'b1
  } chan_t;

  // 74.25 MHz * 245760 / 742500 / 2 = 12.288 MHz mclk
  localparam int MCLK_INCR_DEFAULT = 245760;
  localparam int MCLK_MOD_DEFAULT  = 742500;
  localparam int ACCUM_W           = 22;

  // 32 bit clocks per slot, first 16 carry data
  localparam int I2S_SLOT_BITS = 32;
  localparam int I2S_DATA_BITS = 16;

endpackage

`default_nettype wire

// ==== hw/video/video_sync_cond.sv ====
////////////////////////////////////////
// video sync conditioner
// builds de, masked colour and single
// tick sync pulses for the scaler
////////////////////////////////////////

`timescale 1ns/10ps
`default_nettype none

module video_sync_cond #(
  parameter int hs_delay = core_av_pkg::HS_DELAY_DEFAULT
) (
  input  logic                       clk_74a,
  input  logic                       rst,
  input  logic                       pixel_ce,
  input  core_av_pkg::nes_video_t    nes_video,
  output core_av_pkg::scaler_video_t scaler_video
);

  // countdown wide enough to hold hs_delay
  localparam int CNT_W = $clog2(hs_delay + 1);
  localparam logic [CNT_W-1:0] HS_LOAD = CNT_W'(hs_delay);
  localparam logic [CNT_W-1:0] HS_FIRE = CNT_W'(1);

  // raw sync levels from the previous tick
  logic hsync_prev;
  logic vsync_prev;

  // ticks left until the delayed hs pulse
  logic [CNT_W-1:0] hs_cnt;

  logic hs_rise;
  logic vs_rise;
  logic active;

  ////////////////////////////////////////
  // edge detect and active area

  assign hs_rise = nes_video.hsync & ~hsync_prev;
  assign vs_rise = nes_video.vsync & ~vsync_prev;

  // visible only outside both blanking windows
  assign active = ~(nes_video.hblank | nes_video.vblank);

  ////////////////////////////////////////
  // registered outputs, advance on ticks

  always_ff @(posedge clk_74a) begin
    if (rst) begin
      hsync_prev       <= 1'b0;
      vsync_prev       <= 1'b0;
      hs_cnt           <= '0;
      scaler_video.de  <= 1'b0;
      scaler_video.hs  <= 1'b0;
      scaler_video.vs  <= 1'b0;
      scaler_video.rgb <= '0;
    end else if (pixel_ce) begin
      hsync_prev <= nes_video.hsync;
      vsync_prev <= nes_video.vsync;

      scaler_video.de <= active;
      // black outside the active area
      scaler_video.rgb <= active ? nes_video.color : '0;

      // one tick vs on the raw rising edge
      scaler_video.vs <= vs_rise;

      // hs fires on the last count of the window
      scaler_video.hs <= (hs_cnt == HS_FIRE);

      // fresh edge restarts the window
      if (hs_rise) begin
        hs_cnt <= HS_LOAD;
      end else if (hs_cnt != '0) begin
        hs_cnt <= hs_cnt - HS_FIRE;
      end
    end
  end

  ////////////////////////////////////////
  // checks

  // the hs delay exists to keep the two pulses apart
  a_hs_vs_apart : assert property (
    @(posedge clk_74a) disable iff (rst)
    !(scaler_video.hs && scaler_video.vs)
  );

endmodule

`default_nettype wire

// ==== hw/audio/audio_clock_gen.sv ====
////////////////////////////////////////
// audio clock generator
// fractional mclk from clk_74a, sclk as
// mclk / 4, sclk falling edge strobe
////////////////////////////////////////

`timescale 1ns/10ps
`default_nettype none

module audio_clock_gen #(
  parameter int mclk_incr = core_av_pkg::MCLK_INCR_DEFAULT,
  parameter int mclk_mod  = core_av_pkg::MCLK_MOD_DEFAULT
) (
  input  logic clk_74a,
  input  logic rst,
  output logic audio_mclk,
  output logic audio_sclk,
  output logic sclk_fall
);

  import core_av_pkg::*;

  localparam logic [ACCUM_W-1:0] INCR = ACCUM_W'(mclk_incr);
  localparam logic [ACCUM_W-1:0] MOD  = ACCUM_W'(mclk_mod);

  // phase accumulator, stays below mod + incr
  logic [ACCUM_W-1:0] accum;
  logic               mclk_toggle;
  logic               mclk_rise;

  // mclk rising edge count
  logic [1:0] mclk_div;

  ////////////////////////////////////////
  // master clock

  assign mclk_toggle = (accum >= MOD);
  // toggle while low means mclk goes high next
  assign mclk_rise = mclk_toggle & ~audio_mclk;

  always_ff @(posedge clk_74a) begin
    if (rst) begin
      accum      <= '0;
      audio_mclk <= 1'b0;
    end else if (mclk_toggle) begin
      accum      <= accum - MOD + INCR;
      audio_mclk <= ~audio_mclk;
    end else begin
      accum <= accum + INCR;
    end
  end

  ////////////////////////////////////////
  // bit clock, divide by four

  always_ff @(posedge clk_74a) begin
    if (rst) begin
      mclk_div  <= '0;
      sclk_fall <= 1'b0;
    end else begin
      if (mclk_rise) begin
        mclk_div <= mclk_div + 2'd1;
      end
      // 3 -> 0 drops the top bit, strobe lines up with sclk low
      sclk_fall <= mclk_rise && (mclk_div == 2'd3);
    end
  end

  assign audio_sclk = mclk_div[1];

  // serializer advances once per bit clock
  a_sclk_fall_single : assert property (
    @(posedge clk_74a) disable iff (rst)
    sclk_fall |=> !sclk_fall
  );

endmodule

`default_nettype wire

// ==== hw/audio/i2s_serializer.sv ====
////////////////////////////////////////
// i2s serializer
// one sample holding register, frame
// shifter and lrck, one bit per sclk
////////////////////////////////////////

`timescale 1ns/10ps
`default_nettype none

module i2s_serializer (
  input  logic                       clk_74a,
  input  logic                       rst,
  input  logic                       sclk_fall,
  input  logic                       sample_valid,
  input  core_av_pkg::audio_sample_t sample_data,
  output logic                       sample_ready,
  output logic                       audio_lrck,
  output logic                       audio_dac
);

  import core_av_pkg::*;

  localparam int SLOT_W  = $clog2(I2S_SLOT_BITS);
  localparam int FRAME_W = 2 * I2S_DATA_BITS;
  localparam logic [SLOT_W-1:0] SLOT_LAST = SLOT_W'(I2S_SLOT_BITS - 1);
  localparam logic [SLOT_W-1:0] DATA_END  = SLOT_W'(I2S_DATA_BITS);

  // each channel halved behind a zero bit
  function automatic logic [FRAME_W-1:0] frame_word(audio_sample_t s);
    frame_word = {1'b0, s.left[I2S_DATA_BITS-1:1], 1'b0, s.right[I2S_DATA_BITS-1:1]};
  endfunction

  ////////////////////////////////////////
  // holding register

  audio_sample_t hold_data;
  logic          hold_full;
  // last framed pair for repeats on underrun
  audio_sample_t last_sample;

  logic xfer;
  logic slot_wrap;
  logic frame_start;
  logic take_hold;

  // frame state
  chan_t              chan;
  logic [SLOT_W-1:0]  slot_cnt;
  logic [FRAME_W-1:0] shifter;

  assign sample_ready = ~hold_full;
  assign xfer         = sample_valid & sample_ready;

  // right to left at end of slot starts a frame
  assign slot_wrap   = sclk_fall && (slot_cnt == SLOT_LAST);
  assign frame_start = slot_wrap && (chan == chan_right);
  assign take_hold   = frame_start && hold_full;

  // payload of the held sample
  always_ff @(posedge clk_74a) begin
    if (xfer) begin
      hold_data <= sample_data;
    end
  end

  always_ff @(posedge clk_74a) begin
    if (rst) begin
      hold_full <= 1'b0;
    end else if (xfer) begin
      hold_full <= 1'b1;
    end else if (take_hold) begin
      hold_full <= 1'b0;
    end
  end

  ////////////////////////////////////////
  // shifter and channel

  always_ff @(posedge clk_74a) begin
    if (rst) begin
      chan        <= chan_left;
      slot_cnt    <= '0;
      shifter     <= '0;
      audio_dac   <= 1'b0;
      last_sample <= '0;
    end else if (sclk_fall) begin
      audio_dac <= shifter[FRAME_W-1];
      slot_cnt  <= slot_cnt + SLOT_W'(1);

      if (slot_wrap) begin
        chan <= (chan == chan_left) ? chan_right : chan_left;
        // reload only going right to left
        if (take_hold) begin
          shifter     <= frame_word(hold_data);
          last_sample <= hold_data;
        end else if (frame_start) begin
          shifter <= frame_word(last_sample);
        end
      end else if (slot_cnt < DATA_END) begin
        // 16 shifts per slot then hold
        shifter <= {shifter[FRAME_W-2:0], 1'b0};
      end
    end
  end

  assign audio_lrck = (chan == chan_right);

  // a held sample stays put until a frame takes it
  a_hold_kept : assert property (
    @(posedge clk_74a) disable iff (rst)
    (hold_full && !take_hold) |=> (hold_full && $stable(hold_data))
  );

endmodule

`default_nettype wire

// ==== hw/core_av_top.sv ====
////////////////////////////////////////
// core av top
// video conditioner for the scaler and
// the i2s audio chain, side by side
////////////////////////////////////////

`timescale 1ns/10ps
`default_nettype none

module core_av_top #(
  parameter int hs_delay  = core_av_pkg::HS_DELAY_DEFAULT,
  parameter int mclk_incr = core_av_pkg::MCLK_INCR_DEFAULT,
  parameter int mclk_mod  = core_av_pkg::MCLK_MOD_DEFAULT
) (
  input  logic                       clk_74a,
  input  logic                       rst,

  // raw video, pixel_ce marks a pixel
  input  logic                       pixel_ce,
  input  core_av_pkg::nes_video_t    nes_video,
  output core_av_pkg::scaler_video_t scaler_video,

  // sample stream in
  input  logic                       sample_valid,
  input  core_av_pkg::audio_sample_t sample_data,
  output logic                       sample_ready,

  // i2s pins
  output logic                       audio_mclk,
  output logic                       audio_sclk,
  output logic                       audio_lrck,
  output logic                       audio_dac
);

  // bit clock falling edge as a clk_74a enable
  logic sclk_fall;

  ////////////////////////////////////////
  // video

  video_sync_cond #(
    .hs_delay (hs_delay)
  ) video_sync_cond_inst (
    .clk_74a      (clk_74a),
    .rst          (rst),
    .pixel_ce     (pixel_ce),
    .nes_video    (nes_video),
    .scaler_video (scaler_video)
  );

  ////////////////////////////////////////
  // audio

  audio_clock_gen #(
    .mclk_incr (mclk_incr),
    .mclk_mod  (mclk_mod)
  ) audio_clock_gen_inst (
    .clk_74a    (clk_74a),
    .rst        (rst),
    .audio_mclk (audio_mclk),
    .audio_sclk (audio_sclk),
    .sclk_fall  (sclk_fall)
  );

  // shifts on sclk falling edges from the clock gen
  i2s_serializer i2s_serializer_inst (
    .clk_74a      (clk_74a),
    .rst          (rst),
    .sclk_fall    (sclk_fall),
    .sample_valid (sample_valid),
    .sample_data  (sample_data),
    .sample_ready (sample_ready),
    .audio_lrck   (audio_lrck),
    .audio_dac    (audio_dac)
  );

endmodule

`default_nettype wire

// ==== testbench/tb_core_av_ref.svh ====
////////////////////////////////////////
// core av reference model
// expected video, mclk accumulator and
// i2s frame bits from the protocol rules
////////////////////////////////////////

`ifndef TB_CORE_AV_REF_SVH
`define TB_CORE_AV_REF_SVH

// expected scaler pixel for one tick
// vsync_before is the raw level of the tick before
function automatic scaler_video_t video_expect(
  nes_video_t px,
  logic       vsync_before,
  int         tick,
  int         hs_edge_tick,
  logic       hs_edge_seen,
  int         delay
);
  scaler_video_t v;
  v.de  = !(px.hblank || px.vblank);
  v.rgb = v.de ? px.color : '0;
  v.vs  = px.vsync && !vsync_before;
  // only the latest hsync edge counts
  v.hs  = hs_edge_seen && (tick == hs_edge_tick + delay);
  return v;
endfunction

// accumulator wraps by the modulus once it gets there
function automatic int accum_next(int acc, int incr, int modulus);
  if (acc >= modulus) begin
    return acc - modulus + incr;
  end
  return acc + incr;
endfunction

function automatic logic mclk_toggles(int acc, int modulus);
  return acc >= modulus;
endfunction

// left then right, each halved behind a zero bit
function automatic logic [31:0] build_frame_word(audio_sample_t s);
  return {1'b0, s.left[15:1], 1'b0, s.right[15:1]};
endfunction

// bit on sclk rising edge n of a slot, data on edges 2 to 17
function automatic logic dac_bit(logic [15:0] slot_word, int edge_idx);
  logic [15:0] w;
  if (edge_idx < 2 || edge_idx > 17) begin
    return 1'b0;
  end
  w = slot_word << (edge_idx - 2);
  return w[15];
endfunction

`endif

// ==== testbench/tb_core_av.sv ====
////////////////////////////////////////
// core av testbench
// video conditioner and i2s chain against
// a cycle reference model
////////////////////////////////////////

`timescale 1ns/10ps
`default_nettype none

module tb_core_av;

  import core_av_pkg::*;

  `include "tb_core_av_ref.svh"

  localparam int HS_DELAY    = HS_DELAY_DEFAULT;
  localparam int VID_LINES   = 10;
  localparam int LINE_TICKS  = 48;
  localparam int RUN_FRAMES  = 24;
  // cycles per frame from 64 sclk of 4 mclk of 2 toggles
  localparam int FRAME_CYCLES =
    (2 * I2S_SLOT_BITS * 4 * 2 * MCLK_MOD_DEFAULT) / MCLK_INCR_DEFAULT;
  localparam int CYCLE_LIMIT = 40 * FRAME_CYCLES + 2000;

  logic          clk_74a;
  logic          rst;
  logic          pixel_ce;
  nes_video_t    nes_video;
  scaler_video_t scaler_video;
  logic          sample_valid;
  audio_sample_t sample_data;
  logic          sample_ready;
  logic          audio_mclk;
  logic          audio_sclk;
  logic          audio_lrck;
  logic          audio_dac;

  core_av_top core_av_top_inst (
    .clk_74a      (clk_74a),
    .rst          (rst),
    .pixel_ce     (pixel_ce),
    .nes_video    (nes_video),
    .scaler_video (scaler_video),
    .sample_valid (sample_valid),
    .sample_data  (sample_data),
    .sample_ready (sample_ready),
    .audio_mclk   (audio_mclk),
    .audio_sclk   (audio_sclk),
    .audio_lrck   (audio_lrck),
    .audio_dac    (audio_dac)
  );

  initial clk_74a = 1'b0;
  always #50 clk_74a = ~clk_74a;

  ////////////////////////////////////////
  // reference state

  // video model moves on ticks only
  scaler_video_t exp_video    = '0;
  logic          hsync_before = 1'b0;
  logic          vsync_before = 1'b0;
  logic          hs_edge_seen = 1'b0;
  int            hs_edge_tick = 0;
  int            tick         = 0;
  // clock gen
  int            accum        = 0;
  int            rises        = 0;
  logic          exp_mclk     = 1'b0;
  logic          exp_sclk     = 1'b0;
  logic          sclk_fall_m  = 1'b0;
  // serializer and handshake
  chan_t         exp_chan     = chan_left;
  int            slot         = 0;
  int            edge_idx     = 0;
  int            frames       = 0;
  logic          hold_full_m  = 1'b0;
  audio_sample_t hold_m       = '0;
  audio_sample_t last_m       = '0;
  logic [31:0]   frame_m      = '0;
  logic          xfer_seen    = 1'b0;
  logic          dac_due      = 1'b0;
  logic          exp_dac      = 1'b0;
  int            cycles       = 0;

  task automatic check_value(string name, logic [31:0] got, logic [31:0] expected);
    if (got !== expected) begin
      $display("ERR %s got %h expected %h", name, got, expected);
      $display("TESTBENCH FAILED");
      $fatal(1, "value mismatch");
    end
  endtask

  ////////////////////////////////////////
  // reference model advancing on the rising edge

  always @(posedge clk_74a) begin : model
    logic sclk_was;
    logic xfer;
    logic take;
    if (!rst) begin
      if (pixel_ce) begin
        exp_video = video_expect(nes_video, vsync_before, tick, hs_edge_tick,
                                 hs_edge_seen, HS_DELAY);
        // newest edge restarts the hs window
        if (nes_video.hsync && !hsync_before) begin
          hs_edge_tick = tick;
          hs_edge_seen = 1'b1;
        end
        hsync_before = nes_video.hsync;
        vsync_before = nes_video.vsync;
        tick = tick + 1;
      end

      // handshake and slot state from before this edge
      xfer      = sample_valid && !hold_full_m;
      take      = 1'b0;
      xfer_seen = xfer;
      dac_due   = 1'b0;
      if (sclk_fall_m) begin
        if (slot == I2S_SLOT_BITS - 1) begin
          slot     = 0;
          edge_idx = 0;
          if (exp_chan == chan_right) begin
            // right to left loads a new frame word
            exp_chan = chan_left;
            frames   = frames + 1;
            if (hold_full_m) begin
              last_m = hold_m;
              take   = 1'b1;
            end
            frame_m = build_frame_word(last_m);
          end else begin
            exp_chan = chan_right;
          end
        end else begin
          slot = slot + 1;
        end
      end
      if (xfer) begin
        hold_m      = sample_data;
        hold_full_m = 1'b1;
      end else if (take) begin
        hold_full_m = 1'b0;
      end

      // mclk toggles and sclk from mclk rising edges
      sclk_was = exp_sclk;
      if (mclk_toggles(accum, MCLK_MOD_DEFAULT)) begin
        if (!exp_mclk) begin
          rises = rises + 1;
        end
        exp_mclk = !exp_mclk;
      end
      accum       = accum_next(accum, MCLK_INCR_DEFAULT, MCLK_MOD_DEFAULT);
      exp_sclk    = ((rises % 4) >= 2);
      sclk_fall_m = sclk_was && !exp_sclk;
      if (!sclk_was && exp_sclk) begin
        edge_idx = edge_idx + 1;
        dac_due  = 1'b1;
        exp_dac  = dac_bit(exp_chan == chan_left ? frame_m[31:16] : frame_m[15:0],
                           edge_idx);
      end
    end
  end

  ////////////////////////////////////////
  // compare on the falling edge with outputs settled

  always @(negedge clk_74a) begin : compare
    if (!rst) begin
      check_value("scaler_video", 32'(scaler_video), 32'(exp_video));
      check_value("audio_mclk", 32'(audio_mclk), 32'(exp_mclk));
      check_value("audio_sclk", 32'(audio_sclk), 32'(exp_sclk));
      check_value("audio_lrck", 32'(audio_lrck), 32'(exp_chan));
      check_value("sample_ready", 32'(sample_ready), 32'(!hold_full_m));
      // dac only matters on sclk rising edges
      if (dac_due) begin
        check_value("audio_dac", 32'(audio_dac), 32'(exp_dac));
      end
    end
  end

  always @(posedge clk_74a) begin : watchdog
    cycles = cycles + 1;
    if (cycles >= CYCLE_LIMIT) begin
      $display("TESTBENCH FAILED");
      $fatal(1, "timeout, the audio frames did not finish within %0d cycles", cycles);
    end
  end

  ////////////////////////////////////////
  // stimulus

  // scripted lines and frames with one tick in three cycles
  initial begin : video_stim
    logic [31:0] r;
    pixel_ce  = 1'b0;
    nes_video = '0;
    forever begin
      for (int line = 0; line < VID_LINES; line++) begin
        for (int t = 0; t < LINE_TICKS; t++) begin
          @(negedge clk_74a);
          r = $urandom();
          pixel_ce = 1'b1;
          nes_video.color  = r[23:0];
          nes_video.hblank = r[24] & r[25];
          nes_video.vblank = r[26] & r[27] & r[28];
          // second hsync edge on every third line restarts the count
          nes_video.hsync = (t < 2) || ((line % 3 == 1) && (t == 3 || t == 4));
          // vsync rises mid line away from the hs pulse
          nes_video.vsync = (line < 3 && t >= 20) || (line == 3 && t < 20);
          @(negedge clk_74a);
          pixel_ce = 1'b0;
          @(negedge clk_74a);
        end
      end
    end
  end

  // valid held high then a gap for repeats then random valid
  initial begin : audio_stim
    sample_valid = 1'b0;
    sample_data  = '0;
    wait (!rst);
    sample_data = $urandom();
    forever begin
      @(negedge clk_74a);
      if (xfer_seen) begin
        sample_data = $urandom();
      end
      if (frames < 10) begin
        sample_valid = 1'b1;
      end else if (frames < 13) begin
        sample_valid = 1'b0;
      end else begin
        sample_valid = ($urandom() % 3 != 0);
      end
    end
  end

  initial begin : main
    void'($urandom(32'h7e36b96d));
    rst = 1'b1;
    repeat (8) @(posedge clk_74a);
    @(negedge clk_74a);
    rst = 1'b0;
    wait (frames >= RUN_FRAMES);
    // verdict after the last falling edge compare
    @(negedge clk_74a);
    @(posedge clk_74a);
    $display("TESTBENCH PASSED");
    $finish;
  end

endmodule

`default_nettype wire

// ==== all.f ====
+incdir+testbench
common/core_av_pkg.sv
hw/video/video_sync_cond.sv
hw/audio/audio_clock_gen.sv
hw/audio/i2s_serializer.sv
hw/core_av_top.sv
testbench/tb_core_av.sv

// ==== Makefile ====
# Verilator build of the core av testbench

BIN  := obj_dir/Vtb_core_av
SRCS := $(filter %.sv,$(shell cat all.f)) testbench/tb_core_av_ref.svh

.PHONY: run clean

run: $(BIN)
	./$(BIN)

# rebuilt only when a source or the file list changes
$(BIN): all.f $(SRCS)
	verilator --binary --timing --assert --top-module tb_core_av -f all.f -Mdir obj_dir

clean:
	rm -rf obj_dir
